//--- Bender.yml
package:
  name: rv32i_frontend

sources:
  - files:
      - src/frontend_pkg.sv
      - src/fetch_ctrl.sv
      - src/pc_gen.sv
      - src/gshare_predictor.sv
      - src/ifid_stage.sv
      - src/frontend_top.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/frontend_tb.sv

//--- dv/frontend_model.svh
// ########################################
// Reference model, included inside frontend_tb
// Reads the testbench memory imem by word address
// ########################################
`ifndef FRONTEND_MODEL_SVH
`define FRONTEND_MODEL_SVH

logic [1:0]                        exp_bht [frontend_pkg::BHT_ENTRIES];
logic [frontend_pkg::GHR_BITS-1:0] exp_ghr;
logic [31:0]                       exp_pc;

task automatic reset_model();
    for (int i = 0; i < frontend_pkg::BHT_ENTRIES; i++) begin
        exp_bht[i] = 2'b01;
    end
    exp_ghr = '0;
    exp_pc  = frontend_pkg::RESET_PC;
endtask

// RV32I immediate formats, straight from the instruction bit layout
function automatic logic [31:0] i_imm_of(input logic [31:0] w);
    return {{20{w[31]}}, w[31:20]};
endfunction

function automatic logic [31:0] s_imm_of(input logic [31:0] w);
    return {{20{w[31]}}, w[31:25], w[11:7]};
endfunction

function automatic logic [31:0] b_imm_of(input logic [31:0] w);
    return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
endfunction

function automatic logic [31:0] u_imm_of(input logic [31:0] w);
    return {w[31:12], 12'h000};
endfunction

function automatic logic [31:0] j_imm_of(input logic [31:0] w);
    return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
endfunction

function automatic logic [frontend_pkg::BHT_IDX_BITS-1:0] bht_index(
    input logic [31:0]                       pc,
    input logic [frontend_pkg::GHR_BITS-1:0] h
);
    return pc[9:2] ^ h;
endfunction

function automatic logic predict(input logic [31:0] pc);
    logic [31:0] w;
    w = imem[pc[9:2]];
    if (w[6:0] == frontend_pkg::op_jal) begin
        return 1'b1;
    end
    if (w[6:0] != frontend_pkg::op_br) begin
        return 1'b0;
    end
    // Counter of 2 or 3 means taken
    return exp_bht[bht_index(pc, exp_ghr)] >= 2'd2;
endfunction

task automatic step_transfer(input logic pred);
    logic [31:0] w;
    w = imem[exp_pc[9:2]];
    if (w[6:0] == frontend_pkg::op_br) begin
        exp_ghr = {exp_ghr[frontend_pkg::GHR_BITS-2:0], pred};
    end
    if (!pred) begin
        exp_pc = exp_pc + 32'd4;
    end else if (w[6:0] == frontend_pkg::op_jal) begin
        exp_pc = exp_pc + j_imm_of(w);
    end else begin
        exp_pc = exp_pc + b_imm_of(w);
    end
endtask

task automatic step_resolve(input frontend_pkg::resolve_t r);
    logic [frontend_pkg::BHT_IDX_BITS-1:0] idx;
    idx = bht_index(r.pc, r.ghr);
    case ({r.taken, exp_bht[idx]})
        3'b1_00, 3'b1_01, 3'b1_10: exp_bht[idx] = exp_bht[idx] + 2'd1;
        3'b0_01, 3'b0_10, 3'b0_11: exp_bht[idx] = exp_bht[idx] - 2'd1;
        default: ;
    endcase
    if (r.mispredict) begin
        exp_pc  = r.target;
        exp_ghr = {r.ghr[frontend_pkg::GHR_BITS-2:0], r.taken};
    end
endtask

`endif

//--- dv/frontend_tb.sv
// ########################################
// Random program, stalls and resolutions from a fixed LFSR seed
// Resolutions are synthetic, one every 40 transfers or so
// ########################################
`default_nettype none

module frontend_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_XFERS   = 2000;
    localparam int CYCLE_LIMIT = 20 * NUM_XFERS;
    localparam int RES_EVERY   = 40;

    logic                   clk = 1'b0;
    logic                   rst;
    logic                   imem_req_valid;
    logic                   imem_req_ready;
    logic [31:0]            imem_req_addr;
    logic                   imem_rsp_valid;
    logic [31:0]            imem_rsp_data;
    logic                   out_valid;
    logic                   out_ready;
    frontend_pkg::decoded_t out_pkt;
    logic                   resolve_valid;
    frontend_pkg::resolve_t resolve;

    logic [31:0] imem [256];
    logic [31:0] lfsr_state;

    // Request accepted on the coming edge
    logic        rsp_due;
    logic [31:0] rsp_addr;

    logic                   held;
    frontend_pkg::decoded_t held_pkt;
    logic                   exp_pred;
    int                     xfers;
    int                     xfers_since_res;
    int                     cycles = 0;

    // Last transferred branch, and the one under resolution
    logic [31:0] br_pc;
    logic [7:0]  br_ghr;
    logic        br_pred;
    logic        br_valid;
    logic [31:0] res_pc;
    logic [7:0]  res_ghr;
    logic        res_pred;
    logic        res_valid;

    `include "frontend_model.svh"

    frontend_top frontend_top_inst (
        .clk            (clk),
        .rst            (rst),
        .imem_req_valid (imem_req_valid),
        .imem_req_ready (imem_req_ready),
        .imem_req_addr  (imem_req_addr),
        .imem_rsp_valid (imem_rsp_valid),
        .imem_rsp_data  (imem_rsp_data),
        .out_valid      (out_valid),
        .out_ready      (out_ready),
        .out_pkt        (out_pkt),
        .resolve_valid  (resolve_valid),
        .resolve        (resolve)
    );

    always #10 clk = ~clk;

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] make_instr(input logic [31:0] pc);
        logic [2:0]  kind;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [31:0] off;
        int          o;
        kind = 3'(rand_bits(3));
        rd   = 5'(rand_bits(5));
        rs1  = 5'(rand_bits(5));
        rs2  = 5'(rand_bits(5));
        f3   = 3'(rand_bits(3));
        case (kind)
            3'd0, 3'd1: return {7'(rand_bits(7)), rs2, rs1, f3, rd, frontend_pkg::op_reg};
            3'd2, 3'd3: return {12'(rand_bits(12)), rs1, f3, rd, frontend_pkg::op_imm};
            3'd4:       return {20'(rand_bits(20)), rd, frontend_pkg::op_lui};
            3'd5, 3'd6: begin
                // Offset of -32..28 bytes, never zero, flipped to stay in the table
                o = (int'(rand_bits(4)) - 8) * 4;
                if (o == 0) begin
                    o = 4;
                end
                if (int'(pc) + o < 0 || int'(pc) + o > 1020) begin
                    o = -o;
                end
                if (f3[2:1] == 2'b01) begin
                    f3[2] = 1'b1;
                end
                off = 32'(o);
                return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11],
                        frontend_pkg::op_br};
            end
            default: begin
                // Forward JAL only, so jumps alone never loop
                o = (int'(rand_bits(4)) + 1) * 4;
                if (int'(pc) + o > 1020) begin
                    o = 1020 - int'(pc);
                end
                off = 32'(o);
                return {off[20], off[10:1], off[11], off[19:12], rd, frontend_pkg::op_jal};
            end
        endcase
    endfunction

    task automatic fill_program();
        logic [31:0] back;
        for (int a = 0; a < 255; a++) begin
            imem[a] = make_instr(32'(a * 4));
        end
        // Last word jumps back to the reset address
        back      = frontend_pkg::RESET_PC - 32'h3FC;
        imem[255] = {back[20], back[10:1], back[11], back[19:12], 5'd0, frontend_pkg::op_jal};
    endtask

    task automatic fail_now(input string msg);
        $display("ERR @ %0t ns: %s", $time, msg);
        $display("TEST FAIL");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_transfer(input logic [31:0] w);
        assert (out_pkt.pc == exp_pc)
            else fail_now($sformatf("pc %h, expected %h", out_pkt.pc, exp_pc));
        assert (out_pkt.opcode == w[6:0] && out_pkt.rd == w[11:7] && out_pkt.funct3 == w[14:12]
                && out_pkt.rs1 == w[19:15] && out_pkt.rs2 == w[24:20]
                && out_pkt.funct7 == w[31:25])
            else fail_now($sformatf("fields wrong at %h for word %h", exp_pc, w));
        assert (out_pkt.i_imm == i_imm_of(w) && out_pkt.s_imm == s_imm_of(w)
                && out_pkt.b_imm == b_imm_of(w) && out_pkt.u_imm == u_imm_of(w)
                && out_pkt.j_imm == j_imm_of(w))
            else fail_now($sformatf("immediates wrong at %h for word %h", exp_pc, w));
        assert (out_pkt.pred_taken == exp_pred)
            else fail_now($sformatf("pred_taken %b at %h, expected %b",
                                    out_pkt.pred_taken, exp_pc, exp_pred));
        assert (out_pkt.ghr == exp_ghr)
            else fail_now($sformatf("ghr %h at %h, expected %h", out_pkt.ghr, exp_pc, exp_ghr));
    endtask

    // Sampled mid-cycle, covers the events of the coming edge
    task automatic observe_cycle();
        logic [31:0] w;
        w        = imem[exp_pc[9:2]];
        rsp_due  = imem_req_valid && imem_req_ready;
        rsp_addr = imem_req_addr;
        if (held) begin
            assert (out_valid && out_pkt === held_pkt)
                else fail_now("out_pkt changed while stalled");
        end else if (out_valid) begin
            // Prediction is fixed on the packet's first cycle in IF/ID
            exp_pred = predict(exp_pc);
        end
        if (out_valid && out_ready) begin
            check_transfer(w);
            if (w[6:0] == frontend_pkg::op_br) begin
                br_pc    = exp_pc;
                br_ghr   = exp_ghr;
                br_pred  = exp_pred;
                br_valid = 1'b1;
            end
            step_transfer(exp_pred);
            xfers++;
            xfers_since_res++;
        end
        if (resolve_valid) begin
            step_resolve(resolve);
        end
        held     = out_valid && !out_ready && !(resolve_valid && resolve.mispredict);
        held_pkt = out_pkt;
    endtask

    task automatic send_resolution();
        logic                   taken;
        frontend_pkg::resolve_t r;
        // Half the time the same branch again, to walk its counter
        if (!res_valid || rand_bits(1) == 1) begin
            res_pc    = br_pc;
            res_ghr   = br_ghr;
            res_pred  = br_pred;
            res_valid = 1'b1;
        end
        // Leans taken so some counters reach the taken half
        taken        = (rand_bits(2) != 0);
        r.pc         = res_pc;
        r.ghr        = res_ghr;
        r.taken      = taken;
        r.mispredict = (taken != res_pred);
        r.target     = taken ? res_pc + b_imm_of(imem[res_pc[9:2]]) : res_pc + 32'd4;
        resolve_valid <= 1'b1;
        resolve       <= r;
        xfers_since_res = 0;
    endtask

    task automatic drive_inputs();
        imem_rsp_valid <= rsp_due;
        imem_rsp_data  <= rsp_due ? imem[rsp_addr[9:2]] : rand_bits(32);
        imem_req_ready <= (rand_bits(2) != 0);
        out_ready      <= (rand_bits(2) != 0);
        if (xfers_since_res >= RES_EVERY && br_valid) begin
            send_resolution();
        end else begin
            resolve_valid <= 1'b0;
        end
    endtask

    always @(posedge clk) begin
        if (!rst) begin
            cycles++;
            if (cycles >= CYCLE_LIMIT) begin
                $display("Timeout: only %0d transfers after %0d cycles", xfers, cycles);
                $display("TEST FAIL");
                $fatal(1, "Run did not finish in time");
            end
        end
    end

    initial begin
        rst             = 1'b1;
        imem_req_ready  = 1'b0;
        imem_rsp_valid  = 1'b0;
        imem_rsp_data   = '0;
        out_ready       = 1'b0;
        resolve_valid   = 1'b0;
        resolve         = '0;
        lfsr_state      = 32'd89617;
        rsp_due         = 1'b0;
        rsp_addr        = '0;
        held            = 1'b0;
        held_pkt        = '0;
        exp_pred        = 1'b0;
        xfers           = 0;
        xfers_since_res = 0;
        br_valid        = 1'b0;
        res_valid       = 1'b0;
        fill_program();
        reset_model();
        repeat (9) @(posedge clk);
        @(negedge clk);
        assert (imem_req_valid && imem_req_addr == frontend_pkg::RESET_PC && !out_valid)
            else fail_now("fetch request or out_valid wrong during reset");
        @(posedge clk);
        rst <= 1'b0;
        drive_inputs();
        while (xfers < NUM_XFERS) begin
            @(negedge clk);
            observe_cycle();
            @(posedge clk);
            drive_inputs();
        end
        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- src/fetch_ctrl.sv
// ########################################
// Memory answers exactly one cycle after accept
// One request in flight at most
// ########################################
`default_nettype none

module fetch_ctrl (
    input  logic       clk,
    input  logic       rst,
    input  logic       imem_req_ready,
    input  logic       imem_rsp_valid,
    input  logic       resolve_valid,
    input  logic       resolve_mispredict,
    input  logic       ifid_valid,
    input  logic       skid_full,
    input  logic       out_ready,
    input  logic       redirect_pred,
    input  logic       is_branch,
    output logic       imem_req_valid,
    output logic       rsp_keep,
    output logic       pc_load,
    output logic [1:0] pc_sel,
    output logic       ifid_flush,
    output logic       ghr_push,
    output logic       ghr_restore
);

    logic epoch;
    logic outstanding;
    logic out_epoch;
    logic req_fire;
    logic xfer;
    logic res_redirect;
    logic dec_redirect;

    assign xfer         = ifid_valid && out_ready;
    assign res_redirect = resolve_valid && resolve_mispredict;
    assign dec_redirect = xfer && redirect_pred;

    // Hold off while the in-flight response would have to land in the skid
    // entry, or while the skid entry is still occupied
    assign imem_req_valid = !skid_full && !(outstanding && ifid_valid && !out_ready);
    assign req_fire       = imem_req_valid && imem_req_ready;

    // Drop responses from an old epoch or arriving on a redirect edge
    assign rsp_keep = outstanding && (out_epoch == epoch) && !res_redirect && !dec_redirect;

    assign ifid_flush  = res_redirect || dec_redirect;
    assign pc_load     = req_fire || ifid_flush;
    assign ghr_restore = res_redirect;
    assign ghr_push    = xfer && is_branch && !res_redirect;

    // Resolve beats decode, decode beats sequential
    always_comb begin
        if (res_redirect) begin
            pc_sel = frontend_pkg::PC_SEL_RES;
        end else if (dec_redirect) begin
            pc_sel = frontend_pkg::PC_SEL_DEC;
        end else begin
            pc_sel = frontend_pkg::PC_SEL_SEQ;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            epoch       <= 1'b0;
            outstanding <= 1'b0;
            out_epoch   <= 1'b0;
        end else begin
            if (ifid_flush) begin
                epoch <= ~epoch;
            end
            if (req_fire) begin
                outstanding <= 1'b1;
                // Tag with the epoch seen before any toggle on this edge
                out_epoch   <= epoch;
            end else if (imem_rsp_valid) begin
                outstanding <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/frontend_pkg.sv
// ########################################
// RV32I only; no compressed instructions
// History length must equal the index width
// ########################################
`default_nettype none

package frontend_pkg;

    // First fetch address after reset
    localparam logic [31:0] RESET_PC = 32'h0000_0060;

    localparam int GHR_BITS     = 8;
    localparam int BHT_ENTRIES  = 256;
    localparam int BHT_IDX_BITS = $clog2(BHT_ENTRIES);

    // Next-PC source select
    localparam logic [1:0] PC_SEL_SEQ = 2'd0;
    localparam logic [1:0] PC_SEL_DEC = 2'd1;
    localparam logic [1:0] PC_SEL_RES = 2'd2;

    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } rv_opcode_e;

    // R/S/B/U layout
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instr_reg_t;

    // I/J layout
    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } instr_imm_t;

    typedef union packed {
        instr_reg_t r;
        instr_imm_t i;
    } instr_u;

    typedef struct packed {
        logic [31:0]         pc;
        instr_u              instr;
        logic [GHR_BITS-1:0] ghr;
    } fetch_pkt_t;

    typedef struct packed {
        logic [31:0]         pc;
        rv_opcode_e          opcode;
        logic [2:0]          funct3;
        logic [6:0]          funct7;
        logic [4:0]          rs1;
        logic [4:0]          rs2;
        logic [4:0]          rd;
        logic [31:0]         i_imm;
        logic [31:0]         s_imm;
        logic [31:0]         b_imm;
        logic [31:0]         u_imm;
        logic [31:0]         j_imm;
        logic                pred_taken;
        // History before this instruction's own push
        logic [GHR_BITS-1:0] ghr;
    } decoded_t;

    typedef struct packed {
        logic [31:0]         pc;
        logic [GHR_BITS-1:0] ghr;
        logic                taken;
        logic                mispredict;
        logic [31:0]         target;
    } resolve_t;

endpackage

`default_nettype wire

//--- src/frontend_top.sv
// ########################################
// Resolve is a one-cycle pulse, no ready
// ########################################
`default_nettype none

module frontend_top (
    input  logic                   clk,
    input  logic                   rst,
    output logic                   imem_req_valid,
    input  logic                   imem_req_ready,
    output logic [31:0]            imem_req_addr,
    input  logic                   imem_rsp_valid,
    input  logic [31:0]            imem_rsp_data,
    output logic                   out_valid,
    input  logic                   out_ready,
    output frontend_pkg::decoded_t out_pkt,
    input  logic                   resolve_valid,
    input  frontend_pkg::resolve_t resolve
);

    logic                              rsp_keep;
    logic                              pc_load;
    logic [1:0]                        pc_sel;
    logic                              ifid_flush;
    logic                              ghr_push;
    logic                              ghr_restore;
    logic                              skid_full;
    logic                              is_branch;
    logic                              redirect_pred;
    logic                              pred_taken;
    logic [frontend_pkg::GHR_BITS-1:0] ghr;

    fetch_ctrl fetch_ctrl_inst (
        .clk                (clk),
        .rst                (rst),
        .imem_req_ready     (imem_req_ready),
        .imem_rsp_valid     (imem_rsp_valid),
        .resolve_valid      (resolve_valid),
        .resolve_mispredict (resolve.mispredict),
        .ifid_valid         (out_valid),
        .skid_full          (skid_full),
        .out_ready          (out_ready),
        .redirect_pred      (redirect_pred),
        .is_branch          (is_branch),
        .imem_req_valid     (imem_req_valid),
        .rsp_keep           (rsp_keep),
        .pc_load            (pc_load),
        .pc_sel             (pc_sel),
        .ifid_flush         (ifid_flush),
        .ghr_push           (ghr_push),
        .ghr_restore        (ghr_restore)
    );

    pc_gen pc_gen_inst (
        .clk            (clk),
        .rst            (rst),
        .pc_load        (pc_load),
        .pc_sel         (pc_sel),
        .dec_pkt        (out_pkt),
        .resolve_target (resolve.target),
        .pc             (imem_req_addr)
    );

    gshare_predictor gshare_predictor_inst (
        .clk           (clk),
        .rst           (rst),
        .lookup_pc     (out_pkt.pc),
        .ghr_push      (ghr_push),
        .push_taken    (out_pkt.pred_taken),
        .ghr_restore   (ghr_restore),
        .resolve_valid (resolve_valid),
        .resolve       (resolve),
        .pred_taken    (pred_taken),
        .ghr           (ghr)
    );

    ifid_stage ifid_stage_inst (
        .clk           (clk),
        .rst           (rst),
        .rsp_valid     (imem_rsp_valid),
        .rsp_keep      (rsp_keep),
        .rsp_data      (imem_rsp_data),
        .fetch_pc      (imem_req_addr),
        .ghr           (ghr),
        .flush         (ifid_flush),
        .pred_taken    (pred_taken),
        .out_ready     (out_ready),
        .out_valid     (out_valid),
        .out_pkt       (out_pkt),
        .skid_full     (skid_full),
        .is_branch     (is_branch),
        .redirect_pred (redirect_pred)
    );

endmodule

`default_nettype wire

//--- src/gshare_predictor.sv
// ########################################
// Counters start weakly not-taken
// Restore has priority over a push
// ########################################
`default_nettype none

module gshare_predictor (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [31:0]                         lookup_pc,
    input  logic                                ghr_push,
    input  logic                                push_taken,
    input  logic                                ghr_restore,
    input  logic                                resolve_valid,
    input  frontend_pkg::resolve_t              resolve,
    output logic                                pred_taken,
    output logic [frontend_pkg::GHR_BITS-1:0]   ghr
);

    logic [1:0] bht [frontend_pkg::BHT_ENTRIES];

    logic [frontend_pkg::BHT_IDX_BITS-1:0] lookup_idx;
    logic [frontend_pkg::BHT_IDX_BITS-1:0] train_idx;
    logic [1:0]                            train_ctr;

    // Word-aligned PC bits hashed with history
    assign lookup_idx = lookup_pc[frontend_pkg::BHT_IDX_BITS+1:2]
                      ^ frontend_pkg::BHT_IDX_BITS'(ghr);
    assign train_idx  = resolve.pc[frontend_pkg::BHT_IDX_BITS+1:2]
                      ^ frontend_pkg::BHT_IDX_BITS'(resolve.ghr);

    assign pred_taken = bht[lookup_idx][1];
    assign train_ctr  = bht[train_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < frontend_pkg::BHT_ENTRIES; i++) begin
                bht[i] <= 2'b01;
            end
        end else if (resolve_valid) begin
            // Saturating step toward the actual outcome
            if (resolve.taken && train_ctr != 2'b11) begin
                bht[train_idx] <= train_ctr + 2'd1;
            end else if (!resolve.taken && train_ctr != 2'b00) begin
                bht[train_idx] <= train_ctr - 2'd1;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ghr <= '0;
        end else if (ghr_restore) begin
            ghr <= {resolve.ghr[frontend_pkg::GHR_BITS-2:0], resolve.taken};
        end else if (ghr_push) begin
            ghr <= {ghr[frontend_pkg::GHR_BITS-2:0], push_taken};
        end
    end

endmodule

`default_nettype wire

//--- src/ifid_stage.sv
// ########################################
// Kept responses belong to PC minus 4
// Skid entry fills only while the stage holds
// ########################################
`default_nettype none

module ifid_stage (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              rsp_valid,
    input  logic                              rsp_keep,
    input  logic [31:0]                       rsp_data,
    input  logic [31:0]                       fetch_pc,
    input  logic [frontend_pkg::GHR_BITS-1:0] ghr,
    input  logic                              flush,
    input  logic                              pred_taken,
    input  logic                              out_ready,
    output logic                              out_valid,
    output frontend_pkg::decoded_t            out_pkt,
    output logic                              skid_full,
    output logic                              is_branch,
    output logic                              redirect_pred
);

    frontend_pkg::fetch_pkt_t main_q;
    frontend_pkg::fetch_pkt_t skid_q;
    frontend_pkg::fetch_pkt_t rsp_pkt;
    frontend_pkg::instr_u     ir;
    frontend_pkg::rv_opcode_e opcode;

    logic main_valid;
    logic skid_valid;
    logic take;
    logic xfer;
    logic push_now;
    logic load_main;
    logic main_from_skid;
    logic main_from_rsp;
    logic skid_load;
    logic is_jal;
    logic pred_hold;
    logic pred_q;
    logic pred_use;
    logic pkt_pred;

    function automatic logic [frontend_pkg::GHR_BITS-1:0] advance(
        input logic [frontend_pkg::GHR_BITS-1:0] h,
        input logic                              push,
        input logic                              bit_in
    );
        return push ? {h[frontend_pkg::GHR_BITS-2:0], bit_in} : h;
    endfunction

    assign take = rsp_valid && rsp_keep;
    assign xfer = main_valid && out_ready;

    // History seen by entries once the older branch in IF/ID leaves
    assign push_now = xfer && is_branch;

    // PC has already stepped past the request that is answering now
    assign rsp_pkt.pc    = fetch_pc - 32'd4;
    assign rsp_pkt.instr = rsp_data;
    assign rsp_pkt.ghr   = advance(ghr, push_now, pkt_pred);

    assign load_main      = !flush && (!main_valid || xfer);
    assign main_from_skid = load_main && skid_valid;
    assign main_from_rsp  = load_main && !skid_valid && take;
    assign skid_load      = !flush && take && ((main_valid && !xfer) || skid_valid);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            main_valid <= 1'b0;
            skid_valid <= 1'b0;
            pred_hold  <= 1'b0;
        end else begin
            if (flush) begin
                main_valid <= 1'b0;
            end else if (load_main) begin
                main_valid <= skid_valid || take;
            end
            if (flush) begin
                skid_valid <= 1'b0;
            end else if (skid_load) begin
                skid_valid <= 1'b1;
            end else if (main_from_skid) begin
                skid_valid <= 1'b0;
            end
            // Freeze the prediction once the packet stalls
            pred_hold <= main_valid && !xfer && !flush;
        end
    end

    always_ff @(posedge clk) begin
        if (main_from_skid) begin
            main_q     <= skid_q;
            main_q.ghr <= advance(skid_q.ghr, push_now, pkt_pred);
        end else if (main_from_rsp) begin
            main_q <= rsp_pkt;
        end
        if (skid_load) begin
            skid_q <= rsp_pkt;
        end
        if (!pred_hold) begin
            pred_q <= pred_taken;
        end
    end

    assign ir     = main_q.instr;
    assign opcode = frontend_pkg::rv_opcode_e'(ir.r.opcode);

    assign is_branch     = main_valid && (opcode == frontend_pkg::op_br);
    assign is_jal        = main_valid && (opcode == frontend_pkg::op_jal);
    assign pred_use      = pred_hold ? pred_q : pred_taken;
    assign pkt_pred      = is_jal || (is_branch && pred_use);
    assign redirect_pred = pkt_pred;

    assign out_valid = main_valid;
    assign skid_full = skid_valid;

    always_comb begin
        out_pkt.pc         = main_q.pc;
        out_pkt.opcode     = opcode;
        out_pkt.funct3     = ir.r.funct3;
        out_pkt.funct7     = ir.r.funct7;
        out_pkt.rs1        = ir.r.rs1;
        out_pkt.rs2        = ir.r.rs2;
        out_pkt.rd         = ir.r.rd;
        out_pkt.i_imm      = {{20{ir.i.imm12[11]}}, ir.i.imm12};
        out_pkt.s_imm      = {{20{ir.r.funct7[6]}}, ir.r.funct7, ir.r.rd};
        out_pkt.b_imm      = {{20{ir.r.funct7[6]}}, ir.r.rd[0], ir.r.funct7[5:0],
                              ir.r.rd[4:1], 1'b0};
        out_pkt.u_imm      = {ir.r.funct7, ir.r.rs2, ir.r.rs1, ir.r.funct3, 12'h000};
        // J offset bits 19:12 sit in the rs1 and funct3 slots
        out_pkt.j_imm      = {{12{ir.i.imm12[11]}}, ir.i.rs1, ir.i.funct3, ir.i.imm12[0],
                              ir.i.imm12[10:1], 1'b0};
        out_pkt.pred_taken = pkt_pred;
        out_pkt.ghr        = main_q.ghr;
    end

endmodule

`default_nettype wire

//--- src/pc_gen.sv
// ########################################
// Targets for JAL and conditional branches only
// ########################################
`default_nettype none

module pc_gen (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   pc_load,
    input  logic [1:0]             pc_sel,
    input  frontend_pkg::decoded_t dec_pkt,
    input  logic [31:0]            resolve_target,
    output logic [31:0]            pc
);

    logic [31:0] seq_pc;
    logic [31:0] dec_offset;
    logic [31:0] dec_target;
    logic [31:0] next_pc;

    assign seq_pc = pc + 32'd4;

    // JAL uses the J-format offset, branches the B-format one
    assign dec_offset = (dec_pkt.opcode == frontend_pkg::op_jal) ? dec_pkt.j_imm
                                                                 : dec_pkt.b_imm;
    assign dec_target = dec_pkt.pc + dec_offset;

    always_comb begin
        case (pc_sel)
            frontend_pkg::PC_SEL_DEC: next_pc = dec_target;
            frontend_pkg::PC_SEL_RES: next_pc = resolve_target;
            default:                  next_pc = seq_pc;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= frontend_pkg::RESET_PC;
        end else if (pc_load) begin
            pc <= next_pc;
        end
    end

endmodule

`default_nettype wire

//--- tb.f
+incdir+dv
src/frontend_pkg.sv
src/fetch_ctrl.sv
src/pc_gen.sv
src/gshare_predictor.sv
src/ifid_stage.sv
src/frontend_top.sv
dv/frontend_tb.sv
